// ==== hdl/mpf_params.svh ====
// Width macros shared by the shim package and RTL; include this wherever a width is needed
`ifndef MPF_PARAMS_SVH
`define MPF_PARAMS_SVH

// Transaction tag width
// Four bits give sixteen tags that can be outstanding at once
`define MPF_TAG_BITS 4

// Line address carried by read and write requests
`define MPF_ADDR_BITS 16

// Data word carried by writes and read responses
`define MPF_DATA_BITS 32

// Metadata the AFU attaches to every request
// The tag is zero-extended into this field on the FIU side, so it must be
// at least as wide as the tag
`define MPF_MDATA_BITS 16

`endif

// ==== hdl/mpf_pkg.sv ====
// Request, response and tag RAM types shared by every module of the shim stack
`default_nettype none

`include "mpf_params.svh"

package mpf_pkg;

    // A transaction tag indexes the metadata RAM
    typedef logic [`MPF_TAG_BITS-1:0] mpf_tag_t;

    typedef logic [`MPF_MDATA_BITS-1:0] mpf_mdata_t;

    // Channel 0 carries read requests
    typedef struct packed {
        logic                      valid;
        logic [`MPF_ADDR_BITS-1:0] addr;
        mpf_mdata_t                mdata;
    } mpf_c0_tx_t;

    // Channel 1 carries write requests with their data
    typedef struct packed {
        logic                      valid;
        logic [`MPF_ADDR_BITS-1:0] addr;
        logic [`MPF_DATA_BITS-1:0] data;
        mpf_mdata_t                mdata;
    } mpf_c1_tx_t;

    typedef enum logic {
        RSP_READ  = 1'b0,
        RSP_WRITE = 1'b1
    } mpf_rsp_kind_t;

    // Read response view
    // The spare bit keeps both views the same width
    typedef struct packed {
        mpf_rsp_kind_t kind;
        mpf_mdata_t    mdata;
        logic          rsvd;
        logic          error;
    } mpf_rsp_rd_hdr_t;

    // Write response view with the FIU's write-format code
    typedef struct packed {
        mpf_rsp_kind_t kind;
        mpf_mdata_t    mdata;
        logic [1:0]    format;
    } mpf_rsp_wr_hdr_t;

    // Kind and mdata share the same bits in both views, so either view
    // can be used to find out how to read the rest
    typedef union packed {
        mpf_rsp_rd_hdr_t rd;
        mpf_rsp_wr_hdr_t wr;
    } mpf_rsp_hdr_u;

    typedef struct packed {
        logic                      valid;
        mpf_rsp_hdr_u              hdr;
        logic [`MPF_DATA_BITS-1:0] data;
    } mpf_rx_t;

    // One write into the metadata RAM
    typedef struct packed {
        logic       en;
        mpf_tag_t   tag;
        mpf_mdata_t mdata;
    } mpf_tag_wr_t;

endpackage

`default_nettype wire

// ==== hdl/mpf_req_tagger.sv ====
// Replaces AFU request metadata with rotating tags and tracks how many tags are in flight
`timescale 1ns/1ps
`default_nettype none

`include "mpf_params.svh"

module mpf_req_tagger
(
    input  logic                          clk,
    input  logic                          reset,
    input  mpf_pkg::mpf_c0_tx_t           afu_c0_tx,
    input  mpf_pkg::mpf_c1_tx_t           afu_c1_tx,
    input  logic                          fiu_almost_full_buf,
    input  logic                          rsp_done_c0,
    input  logic                          rsp_done_c1,
    output mpf_pkg::mpf_c0_tx_t           tagged_c0_tx,
    output mpf_pkg::mpf_c1_tx_t           tagged_c1_tx,
    output mpf_pkg::mpf_tag_wr_t [1:0]    tag_wr,
    output logic                          afu_almost_full
);
    import mpf_pkg::*;

    localparam int N_TAGS = 1 << `MPF_TAG_BITS;
    // One extra bit so that a count of N_TAGS fits
    localparam int CNT_BITS = `MPF_TAG_BITS + 1;

    mpf_tag_t            next_tag;
    mpf_tag_t            c0_tag;
    mpf_tag_t            c1_tag;
    logic [1:0]          n_issue;
    logic [1:0]          n_done;
    logic [CNT_BITS-1:0] outstanding;

    // Tags sit in the low bits of the FIU mdata field
    function automatic mpf_mdata_t tag_to_mdata(input mpf_tag_t tag);
        return mpf_mdata_t'(tag);
    endfunction

    // Channel 0 takes the next tag first
    // Channel 1 takes the one after it when both issue in the same cycle
    assign c0_tag = next_tag;
    assign c1_tag = next_tag + mpf_tag_t'(afu_c0_tx.valid);

    assign n_issue = 2'(afu_c0_tx.valid) + 2'(afu_c1_tx.valid);
    assign n_done  = 2'(rsp_done_c0) + 2'(rsp_done_c1);

    always_comb
    begin
        tagged_c0_tx       = afu_c0_tx;
        tagged_c0_tx.mdata = tag_to_mdata(c0_tag);
        tagged_c1_tx       = afu_c1_tx;
        tagged_c1_tx.mdata = tag_to_mdata(c1_tag);

        // The original metadata goes to the RAM slot named by the tag
        tag_wr[0].en    = afu_c0_tx.valid;
        tag_wr[0].tag   = c0_tag;
        tag_wr[0].mdata = afu_c0_tx.mdata;
        tag_wr[1].en    = afu_c1_tx.valid;
        tag_wr[1].tag   = c1_tag;
        tag_wr[1].mdata = afu_c1_tx.mdata;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            next_tag    <= '0;
            outstanding <= '0;
        end
        else
        begin
            next_tag    <= next_tag + mpf_tag_t'(n_issue);
            outstanding <= outstanding + CNT_BITS'(n_issue) - CNT_BITS'(n_done);
        end
    end

    // Two slots of headroom cover a cycle in which both channels issue
    assign afu_almost_full = fiu_almost_full_buf ||
                             (outstanding >= CNT_BITS'(N_TAGS - 2));

endmodule

`default_nettype wire

// ==== hdl/mpf_shim_buffer_fiu.sv ====
// FIU-side buffer that delays responses by one cycle so a RAM lookup can finish in parallel
`timescale 1ns/1ps
`default_nettype none

module mpf_shim_buffer_fiu
#(
    // Nonzero registers the requests and almost-full on their way through
    parameter int REGISTER_OUTBOUND = 0
)
(
    input  logic                clk,
    input  logic                reset,
    input  mpf_pkg::mpf_c0_tx_t buf_c0_tx,
    input  mpf_pkg::mpf_c1_tx_t buf_c1_tx,
    output mpf_pkg::mpf_c0_tx_t raw_c0_tx,
    output mpf_pkg::mpf_c1_tx_t raw_c1_tx,
    input  logic                raw_almost_full,
    output logic                buf_almost_full,
    input  mpf_pkg::mpf_rx_t    raw_c0_rx,
    input  mpf_pkg::mpf_rx_t    raw_c1_rx,
    output mpf_pkg::mpf_rx_t    buf_c0_rx,
    output mpf_pkg::mpf_rx_t    buf_c1_rx
);
    import mpf_pkg::*;

    generate
        if (REGISTER_OUTBOUND == 0)
        begin : g_tx_wire
            // Requests reach the FIU in the cycle the AFU drives them
            assign raw_c0_tx       = buf_c0_tx;
            assign raw_c1_tx       = buf_c1_tx;
            assign buf_almost_full = raw_almost_full;
        end
        else
        begin : g_tx_reg
            // One register stage on the request path and the almost-full return
            always_ff @(posedge clk)
            begin
                raw_c0_tx       <= buf_c0_tx;
                raw_c1_tx       <= buf_c1_tx;
                buf_almost_full <= raw_almost_full;
                if (reset)
                begin
                    raw_c0_tx.valid <= 1'b0;
                    raw_c1_tx.valid <= 1'b0;
                end
            end
        end
    endgenerate

    // Responses always take exactly one cycle through here
    // The header and data follow the valid bit without reset
    always_ff @(posedge clk)
    begin
        buf_c0_rx <= raw_c0_rx;
        buf_c1_rx <= raw_c1_rx;
        if (reset)
        begin
            buf_c0_rx.valid <= 1'b0;
            buf_c1_rx.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mpf_rsp_restore.sv ====
// Tag RAM and response restorer that puts the AFU metadata back into buffered responses
`timescale 1ns/1ps
`default_nettype none

`include "mpf_params.svh"

module mpf_rsp_restore
(
    input  logic                       clk,
    input  logic                       reset,
    input  mpf_pkg::mpf_tag_wr_t [1:0] tag_wr,
    input  mpf_pkg::mpf_rx_t           raw_c0_rx,
    input  mpf_pkg::mpf_rx_t           raw_c1_rx,
    input  mpf_pkg::mpf_rx_t           buf_c0_rx,
    input  mpf_pkg::mpf_rx_t           buf_c1_rx,
    output mpf_pkg::mpf_rx_t           afu_c0_rx,
    output mpf_pkg::mpf_rx_t           afu_c1_rx,
    output logic                       rsp_done_c0,
    output logic                       rsp_done_c1
);
    import mpf_pkg::*;

    localparam int N_TAGS = 1 << `MPF_TAG_BITS;

    // Metadata saved by the tagger, one slot per tag
    mpf_mdata_t mdata_ram [N_TAGS];

    // Per-channel views so both channels share the same code below
    mpf_rx_t    raw_rx     [2];
    mpf_rx_t    buf_rx     [2];
    mpf_rx_t    afu_rx     [2];
    mpf_mdata_t lookup     [2];

    // The FIU echoes the tag in the low mdata bits of either header view
    function automatic mpf_tag_t rsp_tag(input mpf_rx_t rx);
        return rx.hdr.rd.mdata[`MPF_TAG_BITS-1:0];
    endfunction

    // Rebuild a header with the AFU metadata
    // The kind picks which view's extra field survives
    function automatic mpf_rsp_hdr_u restore_hdr(input mpf_rsp_hdr_u hdr,
                                                 input mpf_mdata_t   mdata);
        mpf_rsp_hdr_u res;
        res = '0;
        if (hdr.rd.kind == RSP_READ)
        begin
            res.rd.kind  = RSP_READ;
            res.rd.mdata = mdata;
            res.rd.error = hdr.rd.error;
        end
        else
        begin
            res.wr.kind   = RSP_WRITE;
            res.wr.mdata  = mdata;
            res.wr.format = hdr.wr.format;
        end
        return res;
    endfunction

    assign raw_rx[0] = raw_c0_rx;
    assign raw_rx[1] = raw_c1_rx;
    assign buf_rx[0] = buf_c0_rx;
    assign buf_rx[1] = buf_c1_rx;

    // Two write ports, one per request channel
    // The tagger never hands the same tag to both channels in one cycle
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 2; i++)
        begin
            if (tag_wr[i].en)
            begin
                mdata_ram[tag_wr[i].tag] <= tag_wr[i].mdata;
            end
        end
    end

    // The raw response starts the read, so the result lines up with the buffered copy
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 2; i++)
        begin
            if (raw_rx[i].valid)
            begin
                lookup[i] <= mdata_ram[rsp_tag(raw_rx[i])];
            end
        end
    end

    // The buffered valid comes from the same raw valid that started the lookup
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            afu_rx[i]     = buf_rx[i];
            afu_rx[i].hdr = restore_hdr(buf_rx[i].hdr, lookup[i]);
        end
    end

    assign afu_c0_rx = afu_rx[0];
    assign afu_c1_rx = afu_rx[1];

    // Each delivered response frees its tag in the tagger
    assign rsp_done_c0 = afu_rx[0].valid;
    assign rsp_done_c1 = afu_rx[1].valid;

endmodule

`default_nettype wire

// ==== hdl/mpf_shim_top.sv ====
// Top level of the shim stack, placed between the AFU ports and the FIU ports
`timescale 1ns/1ps
`default_nettype none

module mpf_shim_top
#(
    // Passed to the FIU buffer to register the outbound request path
    parameter int REGISTER_OUTBOUND = 0
)
(
    input  logic                clk,
    input  logic                reset,

    // AFU side
    input  mpf_pkg::mpf_c0_tx_t afu_c0_tx,
    input  mpf_pkg::mpf_c1_tx_t afu_c1_tx,
    output logic                afu_almost_full,
    output mpf_pkg::mpf_rx_t    afu_c0_rx,
    output mpf_pkg::mpf_rx_t    afu_c1_rx,

    // FIU side
    output mpf_pkg::mpf_c0_tx_t fiu_c0_tx,
    output mpf_pkg::mpf_c1_tx_t fiu_c1_tx,
    input  logic                fiu_almost_full,
    input  mpf_pkg::mpf_rx_t    fiu_c0_rx,
    input  mpf_pkg::mpf_rx_t    fiu_c1_rx
);
    import mpf_pkg::*;

    mpf_c0_tx_t        tagged_c0_tx;
    mpf_c1_tx_t        tagged_c1_tx;
    mpf_tag_wr_t [1:0] tag_wr;
    logic              fiu_almost_full_buf;
    mpf_rx_t           buf_c0_rx;
    mpf_rx_t           buf_c1_rx;
    logic              rsp_done_c0;
    logic              rsp_done_c1;

    mpf_req_tagger mpf_req_tagger_inst
    (
        .clk                 (clk),
        .reset               (reset),
        .afu_c0_tx           (afu_c0_tx),
        .afu_c1_tx           (afu_c1_tx),
        .fiu_almost_full_buf (fiu_almost_full_buf),
        .rsp_done_c0         (rsp_done_c0),
        .rsp_done_c1         (rsp_done_c1),
        .tagged_c0_tx        (tagged_c0_tx),
        .tagged_c1_tx        (tagged_c1_tx),
        .tag_wr              (tag_wr),
        .afu_almost_full     (afu_almost_full)
    );

    mpf_shim_buffer_fiu
    #(
        .REGISTER_OUTBOUND (REGISTER_OUTBOUND)
    )
    mpf_shim_buffer_fiu_inst
    (
        .clk             (clk),
        .reset           (reset),
        .buf_c0_tx       (tagged_c0_tx),
        .buf_c1_tx       (tagged_c1_tx),
        .raw_c0_tx       (fiu_c0_tx),
        .raw_c1_tx       (fiu_c1_tx),
        .raw_almost_full (fiu_almost_full),
        .buf_almost_full (fiu_almost_full_buf),
        .raw_c0_rx       (fiu_c0_rx),
        .raw_c1_rx       (fiu_c1_rx),
        .buf_c0_rx       (buf_c0_rx),
        .buf_c1_rx       (buf_c1_rx)
    );

    // The restorer sees the FIU responses directly as well as through the buffer
    mpf_rsp_restore mpf_rsp_restore_inst
    (
        .clk         (clk),
        .reset       (reset),
        .tag_wr      (tag_wr),
        .raw_c0_rx   (fiu_c0_rx),
        .raw_c1_rx   (fiu_c1_rx),
        .buf_c0_rx   (buf_c0_rx),
        .buf_c1_rx   (buf_c1_rx),
        .afu_c0_rx   (afu_c0_rx),
        .afu_c1_rx   (afu_c1_rx),
        .rsp_done_c0 (rsp_done_c0),
        .rsp_done_c1 (rsp_done_c1)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// Clock and reset source for the shim testbench, instantiated once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset drops on a falling edge like every other stimulus
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/mpf_shim_tb.sv ====
// Directed testbench for the shim stack with a simple FIU model; compile with src.f, top mpf_shim_tb
`timescale 1ns/1ps
`default_nettype none

module mpf_shim_tb;
    import mpf_pkg::*;

    localparam logic [31:0] SEED = 32'h3ee8cd94;
    // Requests issued over all tests, used to size the watchdog
    localparam int N_TXN = 29;
    localparam int WATCHDOG_CYCLES = N_TXN * 20 + 500;
    // Write-format code the model returns
    // Its low bit is clear, so a write header read through the read view would lose it
    localparam logic [1:0] WR_FORMAT = 2'b10;

    logic       clk;
    logic       reset;
    mpf_c0_tx_t afu_c0_tx;
    mpf_c1_tx_t afu_c1_tx;
    logic       afu_almost_full;
    mpf_rx_t    afu_c0_rx;
    mpf_rx_t    afu_c1_rx;
    mpf_c0_tx_t fiu_c0_tx;
    mpf_c1_tx_t fiu_c1_tx;
    logic       fiu_almost_full;
    mpf_rx_t    fiu_c0_rx;
    mpf_rx_t    fiu_c1_rx;

    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          seed_ret;
    mpf_tag_t    exp_tag;
    logic        af_last;
    logic [1:0]  fiu_v_prev;
    logic        hold;

    // FIU memory and the testbench's own copy of what it should hold
    logic [31:0] mem        [64];
    logic [31:0] shadow_mem [64];

    // Requests waiting inside the FIU model
    bit          pend_ch    [$];
    mpf_mdata_t  pend_mdata [$];
    logic [15:0] pend_addr  [$];
    int          pend_delay [$];
    mpf_mdata_t  tx_tag_log [$];

    // Responses seen on the AFU side, in arrival order
    mpf_rx_t     rsp_q      [$];
    bit          rsp_ch_q   [$];

    tb_clock_gen clock_gen_inst
    (
        .clk   (clk),
        .reset (reset)
    );

    mpf_shim_top
    #(
        .REGISTER_OUTBOUND (0)
    )
    mpf_shim_top_inst
    (
        .clk             (clk),
        .reset           (reset),
        .afu_c0_tx       (afu_c0_tx),
        .afu_c1_tx       (afu_c1_tx),
        .afu_almost_full (afu_almost_full),
        .afu_c0_rx       (afu_c0_rx),
        .afu_c1_rx       (afu_c1_rx),
        .fiu_c0_tx       (fiu_c0_tx),
        .fiu_c1_tx       (fiu_c1_tx),
        .fiu_almost_full (fiu_almost_full),
        .fiu_c0_rx       (fiu_c0_rx),
        .fiu_c1_rx       (fiu_c1_rx)
    );

    // Initial memory contents depend on every bit of the index
    function automatic logic [31:0] fill_word(input int idx);
        return 32'h5ee00000 ^ (idx * 32'h01030507);
    endfunction

    // The model flags a read error when the low address bits have odd parity
    function automatic logic read_error(input logic [15:0] addr);
        return ^addr[5:0];
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("FAIL %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before)
        begin
            tests_passed++;
            $display("test %s passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - err_before);
        end
    endtask

    // Drives one request for a cycle once almost-full was low at the last rising edge
    task automatic issue_req(input bit is_write, input logic [15:0] addr,
                             input logic [31:0] data, input mpf_mdata_t mdata);
        int log_size;
        @(negedge clk);
        while (af_last)
            @(negedge clk);
        log_size = tx_tag_log.size();
        if (is_write)
        begin
            afu_c1_tx.valid = 1'b1;
            afu_c1_tx.addr  = addr;
            afu_c1_tx.data  = data;
            afu_c1_tx.mdata = mdata;
            shadow_mem[addr[5:0]] = data;
        end
        else
        begin
            afu_c0_tx.valid = 1'b1;
            afu_c0_tx.addr  = addr;
            afu_c0_tx.mdata = mdata;
        end
        @(negedge clk);
        afu_c0_tx = '0;
        afu_c1_tx = '0;
        // The FIU must have seen the request with the next tag in rotation
        if (tx_tag_log.size() != log_size + 1)
        begin
            errors++;
            $display("request with mdata %h never reached the FIU", mdata);
        end
        else
        begin
            check_value("fiu_tag", 64'(exp_tag), 64'(tx_tag_log[log_size]));
        end
        exp_tag = exp_tag + 1'b1;
    endtask

    task automatic wait_rsp(input int n, input string name);
        int cycles;
        cycles = 0;
        while (rsp_q.size() < n && cycles < 200)
        begin
            @(negedge clk);
            cycles++;
        end
        if (rsp_q.size() < n)
        begin
            errors++;
            $display("%s timed out waiting for %0d responses, saw %0d", name, n, rsp_q.size());
        end
    endtask

    task automatic check_header(input string name, input int idx, input bit exp_ch,
                                input mpf_rsp_kind_t exp_kind, input mpf_mdata_t exp_mdata);
        check_value({name, "/channel"}, 64'(exp_ch), 64'(rsp_ch_q[idx]));
        check_value({name, "/kind"}, 64'(exp_kind), 64'(rsp_q[idx].hdr.rd.kind));
        check_value({name, "/mdata"}, 64'(exp_mdata), 64'(rsp_q[idx].hdr.rd.mdata));
    endtask

    task automatic check_reset_state();
        int err_before;
        err_before = errors;
        @(negedge clk);
        check_value("reset_state/afu_c0_rx", 64'd0, 64'(afu_c0_rx.valid));
        check_value("reset_state/afu_c1_rx", 64'd0, 64'(afu_c1_rx.valid));
        check_value("reset_state/fiu_c0_tx", 64'd0, 64'(fiu_c0_tx.valid));
        check_value("reset_state/fiu_c1_tx", 64'd0, 64'(fiu_c1_tx.valid));
        check_value("reset_state/almost_full", 64'd0, 64'(afu_almost_full));
        end_test("reset_state", err_before);
    endtask

    // Address 7 has odd parity, so the model sets the error flag
    task automatic single_read();
        int err_before;
        err_before = errors;
        rsp_q.delete();
        rsp_ch_q.delete();
        issue_req(1'b0, 16'd7, 32'd0, 16'hbeef);
        wait_rsp(1, "single_read");
        if (rsp_q.size() == 1)
        begin
            check_header("single_read", 0, 1'b0, RSP_READ, 16'hbeef);
            check_value("single_read/data", 64'(shadow_mem[7]), 64'(rsp_q[0].data));
            check_value("single_read/error", 64'(read_error(16'd7)),
                        64'(rsp_q[0].hdr.rd.error));
        end
        end_test("single_read", err_before);
    endtask

    task automatic write_then_read();
        int err_before;
        err_before = errors;
        rsp_q.delete();
        rsp_ch_q.delete();
        issue_req(1'b1, 16'd9, 32'h12345678, 16'h1111);
        wait_rsp(1, "write_then_read");
        if (rsp_q.size() == 1)
        begin
            check_header("write_then_read/wr", 0, 1'b1, RSP_WRITE, 16'h1111);
            check_value("write_then_read/format", 64'(WR_FORMAT),
                        64'(rsp_q[0].hdr.wr.format));
        end
        issue_req(1'b0, 16'd9, 32'd0, 16'h2222);
        wait_rsp(2, "write_then_read");
        if (rsp_q.size() == 2)
        begin
            check_header("write_then_read/rd", 1, 1'b0, RSP_READ, 16'h2222);
            check_value("write_then_read/data", 64'h12345678, 64'(rsp_q[1].data));
        end
        end_test("write_then_read", err_before);
    endtask

    // Distinct addresses per request keep the expected data independent of response order
    task automatic mixed_traffic();
        int          err_before;
        int          found;
        mpf_mdata_t  sb_mdata [12];
        bit          sb_write [12];
        logic [15:0] sb_addr  [12];
        bit          sb_seen  [12];
        logic [31:0] wdata;
        err_before = errors;
        rsp_q.delete();
        rsp_ch_q.delete();
        for (int i = 0; i < 12; i++)
        begin
            // Low bits hold the index so every mdata is unique
            sb_mdata[i] = {12'($urandom() % 4096), i[3:0]};
            sb_write[i] = $urandom() % 2;
            sb_addr[i]  = sb_write[i] ? 16'(32 + i) : 16'(48 + i);
            sb_seen[i]  = 1'b0;
            wdata       = $urandom();
            issue_req(sb_write[i], sb_addr[i], wdata, sb_mdata[i]);
        end
        wait_rsp(12, "mixed_traffic");
        // Extra responses would show up here
        repeat (20) @(negedge clk);
        check_value("mixed_traffic/count", 64'd12, 64'(rsp_q.size()));
        for (int r = 0; r < rsp_q.size(); r++)
        begin
            found = -1;
            for (int j = 0; j < 12; j++)
            begin
                if (sb_mdata[j] == rsp_q[r].hdr.rd.mdata)
                    found = j;
            end
            if (found < 0)
            begin
                errors++;
                $display("mixed_traffic got a response with unknown mdata %h",
                         rsp_q[r].hdr.rd.mdata);
            end
            else if (sb_seen[found])
            begin
                errors++;
                $display("mixed_traffic got a second response for mdata %h", sb_mdata[found]);
            end
            else
            begin
                sb_seen[found] = 1'b1;
                check_value("mixed_traffic/channel", 64'(sb_write[found]), 64'(rsp_ch_q[r]));
                check_value("mixed_traffic/kind",
                            64'(sb_write[found] ? RSP_WRITE : RSP_READ),
                            64'(rsp_q[r].hdr.rd.kind));
                if (sb_write[found])
                begin
                    check_value("mixed_traffic/format", 64'(WR_FORMAT),
                                64'(rsp_q[r].hdr.wr.format));
                end
                else
                begin
                    check_value("mixed_traffic/data", 64'(shadow_mem[sb_addr[found][5:0]]),
                                64'(rsp_q[r].data));
                    check_value("mixed_traffic/error", 64'(read_error(sb_addr[found])),
                                64'(rsp_q[r].hdr.rd.error));
                end
            end
        end
        for (int j = 0; j < 12; j++)
        begin
            if (!sb_seen[j])
            begin
                errors++;
                $display("mixed_traffic never got a response for mdata %h", sb_mdata[j]);
            end
        end
        end_test("mixed_traffic", err_before);
    endtask

    task automatic almost_full_levels();
        int err_before;
        err_before = errors;
        rsp_q.delete();
        rsp_ch_q.delete();
        @(negedge clk);
        fiu_almost_full = 1'b1;
        @(negedge clk);
        check_value("almost_full/fiu_high", 64'd1, 64'(afu_almost_full));
        fiu_almost_full = 1'b0;
        @(negedge clk);
        check_value("almost_full/fiu_low", 64'd0, 64'(afu_almost_full));
        // The model sits on its responses until 14 tags are in flight
        hold = 1'b1;
        for (int i = 0; i < 14; i++)
            issue_req(1'b0, 16'(i), 32'd0, 16'(16'h6000 + i));
        @(negedge clk);
        check_value("almost_full/outstanding", 64'd1, 64'(afu_almost_full));
        hold = 1'b0;
        wait_rsp(14, "almost_full");
        @(negedge clk);
        check_value("almost_full/drained", 64'd0, 64'(afu_almost_full));
        end_test("almost_full", err_before);
    endtask

    // FIU model request side; writes land in memory as soon as they are seen
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (fiu_c0_tx.valid)
            begin
                pend_ch.push_back(1'b0);
                pend_mdata.push_back(fiu_c0_tx.mdata);
                pend_addr.push_back(fiu_c0_tx.addr);
                pend_delay.push_back($urandom_range(8, 1));
                tx_tag_log.push_back(fiu_c0_tx.mdata);
            end
            if (fiu_c1_tx.valid)
            begin
                mem[fiu_c1_tx.addr[5:0]] = fiu_c1_tx.data;
                pend_ch.push_back(1'b1);
                pend_mdata.push_back(fiu_c1_tx.mdata);
                pend_addr.push_back(fiu_c1_tx.addr);
                pend_delay.push_back($urandom_range(8, 1));
                tx_tag_log.push_back(fiu_c1_tx.mdata);
            end
        end
    end

    // FIU model response side
    // At most one response per channel per cycle, picked from a random starting point
    always @(negedge clk)
    begin : fiu_rsp
        int      idx;
        int      start;
        int      j;
        mpf_rx_t rx;
        for (int ch = 0; ch < 2; ch++)
        begin
            rx  = '0;
            idx = -1;
            if (!hold && pend_ch.size() > 0)
            begin
                if (ch == 0)
                begin
                    for (int k = 0; k < pend_delay.size(); k++)
                        if (pend_delay[k] > 0)
                            pend_delay[k]--;
                end
                start = $urandom_range(pend_ch.size() - 1, 0);
                for (int k = 0; k < pend_ch.size(); k++)
                begin
                    j = (start + k) % pend_ch.size();
                    if (idx < 0 && pend_ch[j] == ch[0] && pend_delay[j] == 0)
                        idx = j;
                end
            end
            if (idx >= 0)
            begin
                rx.valid = 1'b1;
                if (ch == 0)
                begin
                    rx.hdr.rd.kind  = RSP_READ;
                    rx.hdr.rd.mdata = pend_mdata[idx];
                    rx.hdr.rd.error = read_error(pend_addr[idx]);
                    rx.data         = mem[pend_addr[idx][5:0]];
                end
                else
                begin
                    rx.hdr.wr.kind   = RSP_WRITE;
                    rx.hdr.wr.mdata  = pend_mdata[idx];
                    rx.hdr.wr.format = WR_FORMAT;
                end
                pend_ch.delete(idx);
                pend_mdata.delete(idx);
                pend_addr.delete(idx);
                pend_delay.delete(idx);
            end
            if (ch == 0)
                fiu_c0_rx = rx;
            else
                fiu_c1_rx = rx;
        end
    end

    // AFU side monitor
    // Each AFU response valid must match the FIU response valid of the cycle before
    always @(posedge clk)
    begin
        if (!reset)
        begin
            check_value("rx_timing_c0", 64'(fiu_v_prev[0]), 64'(afu_c0_rx.valid));
            check_value("rx_timing_c1", 64'(fiu_v_prev[1]), 64'(afu_c1_rx.valid));
            if (afu_c0_rx.valid)
            begin
                rsp_q.push_back(afu_c0_rx);
                rsp_ch_q.push_back(1'b0);
            end
            if (afu_c1_rx.valid)
            begin
                rsp_q.push_back(afu_c1_rx);
                rsp_ch_q.push_back(1'b1);
            end
        end
        fiu_v_prev = {fiu_c1_rx.valid, fiu_c0_rx.valid};
        af_last    = afu_almost_full;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run hung after %0d cycles without finishing the tests", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        seed_ret        = $urandom(SEED);
        afu_c0_tx       = '0;
        afu_c1_tx       = '0;
        fiu_almost_full = 1'b0;
        fiu_c0_rx       = '0;
        fiu_c1_rx       = '0;
        hold            = 1'b0;
        errors          = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        exp_tag         = '0;
        af_last         = 1'b0;
        fiu_v_prev      = 2'b00;
        for (int i = 0; i < 64; i++)
        begin
            mem[i]        = fill_word(i);
            shadow_mem[i] = fill_word(i);
        end
        @(negedge clk);
        while (reset)
            @(negedge clk);
        check_reset_state();
        single_read();
        write_then_read();
        mixed_traffic();
        almost_full_levels();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
hdl/mpf_pkg.sv
hdl/mpf_req_tagger.sv
hdl/mpf_shim_buffer_fiu.sv
hdl/mpf_rsp_restore.sv
hdl/mpf_shim_top.sv
sim/tb_clock_gen.sv
sim/mpf_shim_tb.sv
